// ==== Makefile ====
# Verilator simulation of the eai matrix core

TOP := tb_eai_matrix
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== hdl/eai_cmd_ctrl.sv ====
/*
 * eai command controller
 * decodes custom-0 requests, fires the start pulses for setup, row sum
 * and column sum, and keeps one instruction in flight at a time
 */
`timescale 1ns/1ps
`include "eai_consts.svh"

module eai_cmd_ctrl
   import eai_pkg::*;
(
   input  logic  eai_clk,
   input  logic  eai_rst_n,
   input  logic  req_valid,
   input  xlen_t req_inst,
   input  xlen_t req_rs1,
   input  xlen_t req_rs2,
   input  logic  row_done,
   input  logic  rsp_taken,
   output logic  req_ready,
   output logic  setup_load,
   output logic  row_start,
   output logic  col_start,
   output xlen_t op_a,
   output xlen_t op_b,
   output logic  mem_holdup
);

   eai_state_e state_q;
   eai_state_e state_d;
   eai_op_e    op;
   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       req_fire;
   logic       holdup_q;

   // =========================================================================
   // decode
   // =========================================================================
   assign opcode = req_inst[6:0];
   assign funct3 = req_inst[14:12];
   assign funct7 = req_inst[31:25];

   always_comb
   begin
      op = OP_NONE;
      if (opcode == `EAI_OPC_CUSTOM0)
      begin
         if (funct3 == `EAI_F3_SETUP && funct7 == `EAI_F7_SETUP)
            op = OP_SETUP;
         else if (funct3 == `EAI_F3_SUM && funct7 == `EAI_F7_ROWSUM)
            op = OP_ROWSUM;
         else if (funct3 == `EAI_F3_SUM && funct7 == `EAI_F7_COLSUM)
            op = OP_COLSUM;
      end
   end

   assign req_ready  = (state_q == ST_IDLE);
   assign req_fire   = req_valid & req_ready;
   // undecoded requests are taken with no pulse
   assign setup_load = req_fire & (op == OP_SETUP);
   assign row_start  = req_fire & (op == OP_ROWSUM);
   assign col_start  = req_fire & (op == OP_COLSUM);
   assign op_a       = req_rs1;
   assign op_b       = req_rs2;

   // =========================================================================
   // controller FSM
   // =========================================================================
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         ST_IDLE:
            if (setup_load || col_start)
               state_d = ST_RSP_WAIT;
            else if (row_start)
               state_d = ST_ROW_BUSY;
         ST_ROW_BUSY:
            if (row_done)
               state_d = ST_RSP_WAIT;
         ST_RSP_WAIT:
            if (rsp_taken)
               state_d = ST_IDLE;
         default:
            state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge eai_clk or negedge eai_rst_n)
   begin
      if (!eai_rst_n)
      begin
         state_q  <= ST_IDLE;
         holdup_q <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         // memory held for the host through a whole row sum
         if (row_start)
            holdup_q <= 1'b1;
         else if (rsp_taken)
            holdup_q <= 1'b0;
      end
   end

   assign mem_holdup = holdup_q;

endmodule

// ==== hdl/eai_col_lane.sv ====
/*
 * eai column lane
 * running total of one matrix column, restarted by a row 0 word
 */
`timescale 1ns/1ps

module eai_col_lane
   import eai_pkg::*;
(
   input  logic  eai_clk,
   input  logic  eai_rst_n,
   input  logic  wr,
   input  logic  first,
   input  xlen_t word,
   output xlen_t total
);

   xlen_t total_q;

   always_ff @(posedge eai_clk or negedge eai_rst_n)
   begin
      if (!eai_rst_n)
      begin
         total_q <= '0;
      end
      else if (wr)
      begin
         // row 0 starts a fresh column
         if (first)
            total_q <= word;
         else
            total_q <= total_q + word;
      end
   end

   assign total = total_q;

endmodule

// ==== hdl/eai_consts.svh ====
/*
 * eai matrix coprocessor constants
 * widths, custom-0 decode values, matrix dimension and icb bus codes
 */
`ifndef EAI_CONSTS_SVH
`define EAI_CONSTS_SVH

`define EAI_XLEN           32
`define EAI_ADDR_SIZE      32
`define EAI_MATRIX_DIM     3

// custom-0 decode fields
`define EAI_OPC_CUSTOM0    7'b0001011
`define EAI_F3_SETUP       3'b011
`define EAI_F3_SUM         3'b110
`define EAI_F7_SETUP       7'd0
`define EAI_F7_ROWSUM      7'd1
`define EAI_F7_COLSUM      7'd2

// icb side
`define EAI_WORD_BYTES     4
`define EAI_ICB_SIZE_WORD  2'b10

`endif

// ==== hdl/eai_matrix_core.sv ====
/*
 * eai matrix core
 * custom-0 coprocessor for row and column sums of a matrix in memory,
 * built from the controller, row fetch, column lanes and response select
 */
`timescale 1ns/1ps
`include "eai_consts.svh"

module eai_matrix_core
   import eai_pkg::*;
(
   input  logic        eai_clk,
   input  logic        eai_rst_n,
   output logic        eai_active,
   output logic        eai_mem_holdup,
   // host request
   input  logic        eai_req_valid,
   output logic        eai_req_ready,
   input  xlen_t       eai_req_inst,
   input  xlen_t       eai_req_rs1,
   input  xlen_t       eai_req_rs2,
   // host response
   output logic        eai_rsp_valid,
   input  logic        eai_rsp_ready,
   output xlen_t       eai_rsp_rdat,
   output logic        eai_rsp_err,
   // icb command
   output logic        eai_icb_cmd_valid,
   input  logic        eai_icb_cmd_ready,
   output addr_t       eai_icb_cmd_addr,
   output logic        eai_icb_cmd_read,
   output xlen_t       eai_icb_cmd_wdata,
   output logic [1:0]  eai_icb_cmd_size,
   // icb response, errors are not passed on
   input  logic        eai_icb_rsp_valid,
   output logic        eai_icb_rsp_ready,
   input  xlen_t       eai_icb_rsp_rdata,
   input  logic        eai_icb_rsp_err
);

   logic       setup_load;
   logic       row_start;
   logic       col_start;
   logic       row_done;
   logic       rsp_taken;
   logic       lane_first;
   xlen_t      op_a;
   xlen_t      op_b;
   xlen_t      row_sum;
   xlen_t      lane_word;
   lane_mask_t lane_wr;
   xlen_t      lane_total [`EAI_MATRIX_DIM];

   eai_cmd_ctrl u_ctrl (
      .eai_clk    (eai_clk),
      .eai_rst_n  (eai_rst_n),
      .req_valid  (eai_req_valid),
      .req_inst   (eai_req_inst),
      .req_rs1    (eai_req_rs1),
      .req_rs2    (eai_req_rs2),
      .row_done   (row_done),
      .rsp_taken  (rsp_taken),
      .req_ready  (eai_req_ready),
      .setup_load (setup_load),
      .row_start  (row_start),
      .col_start  (col_start),
      .op_a       (op_a),
      .op_b       (op_b),
      .mem_holdup (eai_mem_holdup)
   );

   eai_row_fetch u_fetch (
      .eai_clk       (eai_clk),
      .eai_rst_n     (eai_rst_n),
      .setup_load    (setup_load),
      .row_start     (row_start),
      .op_a          (op_a),
      .op_b          (op_b),
      .icb_cmd_ready (eai_icb_cmd_ready),
      .icb_rsp_valid (eai_icb_rsp_valid),
      .icb_rsp_rdata (eai_icb_rsp_rdata),
      .icb_cmd_valid (eai_icb_cmd_valid),
      .icb_cmd_addr  (eai_icb_cmd_addr),
      .lane_wr       (lane_wr),
      .lane_first    (lane_first),
      .lane_word     (lane_word),
      .row_done      (row_done),
      .row_sum       (row_sum)
   );

   // one lane per matrix column
   for (genvar i = 0; i < `EAI_MATRIX_DIM; i++)
   begin : g_lane
      eai_col_lane u_lane (
         .eai_clk   (eai_clk),
         .eai_rst_n (eai_rst_n),
         .wr        (lane_wr[i]),
         .first     (lane_first),
         .word      (lane_word),
         .total     (lane_total[i])
      );
   end

   eai_rsp_sel u_rsp (
      .eai_clk    (eai_clk),
      .eai_rst_n  (eai_rst_n),
      .setup_load (setup_load),
      .row_done   (row_done),
      .row_sum    (row_sum),
      .col_start  (col_start),
      .op_a       (op_a),
      .lane_total (lane_total),
      .rsp_ready  (eai_rsp_ready),
      .rsp_valid  (eai_rsp_valid),
      .rsp_rdat   (eai_rsp_rdat),
      .rsp_taken  (rsp_taken)
   );

   // read-only word access, always ready for memory data
   assign eai_icb_cmd_read  = 1'b1;
   assign eai_icb_cmd_size  = `EAI_ICB_SIZE_WORD;
   assign eai_icb_cmd_wdata = '0;
   assign eai_icb_rsp_ready = 1'b1;
   assign eai_rsp_err       = 1'b0;
   assign eai_active        = 1'b1;

endmodule

// ==== hdl/eai_pkg.sv ====
/*
 * eai matrix coprocessor types
 * data and address words, lane index and strobe, decode and FSM enums
 */
`include "eai_consts.svh"

package eai_pkg;

   typedef logic [`EAI_XLEN-1:0]       xlen_t;
   typedef logic [`EAI_ADDR_SIZE-1:0]  addr_t;
   typedef logic [1:0]                 lane_idx_t;
   typedef logic [`EAI_MATRIX_DIM-1:0] lane_mask_t;

   // decoded custom-0 operation
   typedef enum logic [1:0] {
      OP_NONE,
      OP_SETUP,
      OP_ROWSUM,
      OP_COLSUM
   } eai_op_e;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ROW_BUSY,
      ST_RSP_WAIT
   } eai_state_e;

endpackage

// ==== hdl/eai_row_fetch.sv ====
/*
 * eai row fetch
 * holds the matrix base and row length, reads one row word by word over
 * icb, sums the row and steers each word to its column lane
 */
`timescale 1ns/1ps
`include "eai_consts.svh"

module eai_row_fetch
   import eai_pkg::*;
(
   input  logic       eai_clk,
   input  logic       eai_rst_n,
   input  logic       setup_load,
   input  logic       row_start,
   input  xlen_t      op_a,
   input  xlen_t      op_b,
   input  logic       icb_cmd_ready,
   input  logic       icb_rsp_valid,
   input  xlen_t      icb_rsp_rdata,
   output logic       icb_cmd_valid,
   output addr_t      icb_cmd_addr,
   output lane_mask_t lane_wr,
   output logic       lane_first,
   output xlen_t      lane_word,
   output logic       row_done,
   output xlen_t      row_sum
);

   localparam lane_idx_t LAST_WORD = lane_idx_t'(`EAI_MATRIX_DIM - 1);

   addr_t     base_q;
   xlen_t     len_q;
   addr_t     row_addr;
   addr_t     addr_q;
   xlen_t     sum_q;
   lane_idx_t word_cnt_q;
   logic      busy_q;
   logic      cmd_valid_q;
   logic      row_zero_q;
   logic      word_fire;

   // base + row * len * 4
   assign row_addr  = base_q + addr_t'(op_a * len_q * `EAI_WORD_BYTES);
   assign word_fire = busy_q & icb_rsp_valid;
   assign row_done  = word_fire & (word_cnt_q == LAST_WORD);

   always_ff @(posedge eai_clk or negedge eai_rst_n)
   begin
      if (!eai_rst_n)
      begin
         base_q <= '0;
         len_q  <= '0;
      end
      else if (setup_load)
      begin
         base_q <= addr_t'(op_a);
         len_q  <= op_b;
      end
   end

   // =========================================================================
   // read sequencing, one command outstanding
   // =========================================================================
   always_ff @(posedge eai_clk or negedge eai_rst_n)
   begin
      if (!eai_rst_n)
      begin
         busy_q      <= 1'b0;
         cmd_valid_q <= 1'b0;
         word_cnt_q  <= '0;
         row_zero_q  <= 1'b0;
      end
      else if (row_start)
      begin
         busy_q      <= 1'b1;
         cmd_valid_q <= 1'b1;
         word_cnt_q  <= '0;
         row_zero_q  <= (op_a == '0);
      end
      else
      begin
         if (icb_cmd_valid && icb_cmd_ready)
            cmd_valid_q <= 1'b0;
         if (word_fire)
         begin
            word_cnt_q <= word_cnt_q + 1'b1;
            if (row_done)
               busy_q <= 1'b0;
            else
               cmd_valid_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge eai_clk)
   begin
      if (row_start)
      begin
         addr_q <= row_addr;
         sum_q  <= '0;
      end
      else if (word_fire)
      begin
         addr_q <= addr_q + addr_t'(`EAI_WORD_BYTES);
         sum_q  <= row_sum;
      end
   end

   assign icb_cmd_valid = cmd_valid_q;
   assign icb_cmd_addr  = addr_q;
   assign row_sum       = sum_q + icb_rsp_rdata;
   // word n of the row goes to lane n
   assign lane_wr       = word_fire ? (lane_mask_t'(1) << word_cnt_q) : '0;
   assign lane_first    = row_zero_q;
   assign lane_word     = icb_rsp_rdata;

endmodule

// ==== hdl/eai_rsp_sel.sv ====
/*
 * eai response select
 * registers the result word of each instruction and holds it on the
 * host response port until the host takes it
 */
`timescale 1ns/1ps
`include "eai_consts.svh"

module eai_rsp_sel
   import eai_pkg::*;
(
   input  logic  eai_clk,
   input  logic  eai_rst_n,
   input  logic  setup_load,
   input  logic  row_done,
   input  xlen_t row_sum,
   input  logic  col_start,
   input  xlen_t op_a,
   input  xlen_t lane_total [`EAI_MATRIX_DIM],
   input  logic  rsp_ready,
   output logic  rsp_valid,
   output xlen_t rsp_rdat,
   output logic  rsp_taken
);

   xlen_t col_word;
   xlen_t rdat_q;
   logic  valid_q;
   logic  capture;

   // columns past the last lane read as 0
   always_comb
   begin
      col_word = '0;
      for (int i = 0; i < `EAI_MATRIX_DIM; i++)
      begin
         if (op_a == xlen_t'(i))
            col_word = lane_total[i];
      end
   end

   assign capture   = setup_load | row_done | col_start;
   assign rsp_taken = valid_q & rsp_ready;

   always_ff @(posedge eai_clk or negedge eai_rst_n)
   begin
      if (!eai_rst_n)
         valid_q <= 1'b0;
      else if (capture)
         valid_q <= 1'b1;
      else if (rsp_taken)
         valid_q <= 1'b0;
   end

   always_ff @(posedge eai_clk)
   begin
      if (setup_load)
         rdat_q <= '0;
      else if (row_done)
         rdat_q <= row_sum;
      else if (col_start)
         rdat_q <= col_word;
   end

   assign rsp_valid = valid_q;
   assign rsp_rdat  = rdat_q;

endmodule

// ==== list.f ====
+incdir+hdl
hdl/eai_pkg.sv
hdl/eai_cmd_ctrl.sv
hdl/eai_row_fetch.sv
hdl/eai_col_lane.sv
hdl/eai_rsp_sel.sv
hdl/eai_matrix_core.sv
test/eai_matrix_props.sv
test/tb_eai_matrix.sv

// ==== test/eai_matrix_props.sv ====
/*
 * eai matrix core protocol assertions
 * valid hold, stalled command address and request blocking
 */
`timescale 1ns/1ps

module eai_matrix_props
   import eai_pkg::*;
(
   input logic  eai_clk,
   input logic  eai_rst_n,
   input logic  req_ready,
   input logic  rsp_valid,
   input logic  rsp_ready,
   input logic  icb_cmd_valid,
   input logic  icb_cmd_ready,
   input addr_t icb_cmd_addr
);

   a_cmd_hold: assert property (@(posedge eai_clk) disable iff (!eai_rst_n)
      icb_cmd_valid && !icb_cmd_ready |=> icb_cmd_valid)
      else $error("icb command valid dropped before its transfer");

   // address stays put through a stall
   a_addr_stable: assert property (@(posedge eai_clk) disable iff (!eai_rst_n)
      icb_cmd_valid && !icb_cmd_ready |=> $stable(icb_cmd_addr))
      else $error("icb command address changed while stalled");

   a_rsp_hold: assert property (@(posedge eai_clk) disable iff (!eai_rst_n)
      rsp_valid && !rsp_ready |=> rsp_valid)
      else $error("response valid dropped before its transfer");

   a_req_block: assert property (@(posedge eai_clk) disable iff (!eai_rst_n)
      rsp_valid |-> !req_ready)
      else $error("request ready high while a response is pending");

endmodule

bind eai_matrix_core eai_matrix_props u_props (
   .eai_clk       (eai_clk),
   .eai_rst_n     (eai_rst_n),
   .req_ready     (eai_req_ready),
   .rsp_valid     (eai_rsp_valid),
   .rsp_ready     (eai_rsp_ready),
   .icb_cmd_valid (eai_icb_cmd_valid),
   .icb_cmd_ready (eai_icb_cmd_ready),
   .icb_cmd_addr  (eai_icb_cmd_addr)
);

// ==== test/tb_eai_matrix.sv ====
/*
 * testbench for the eai matrix core
 * host request driver, icb memory model with random delay and stalls,
 * directed tests for setup, row sum, column sum and back-pressure
 */
`timescale 1ns/1ps
`include "eai_consts.svh"

module tb_eai_matrix
   import eai_pkg::*;
();

   localparam int CLK_PERIOD  = 100;
   localparam int NUM_TESTS   = 5;
   localparam int TEST_CYCLES = 400;
   localparam int RSP_LIMIT   = 60;

   logic       eai_clk;
   logic       eai_rst_n;
   logic       eai_active;
   logic       eai_mem_holdup;
   logic       eai_req_valid;
   logic       eai_req_ready;
   xlen_t      eai_req_inst;
   xlen_t      eai_req_rs1;
   xlen_t      eai_req_rs2;
   logic       eai_rsp_valid;
   logic       eai_rsp_ready;
   xlen_t      eai_rsp_rdat;
   logic       eai_rsp_err;
   logic       eai_icb_cmd_valid;
   logic       eai_icb_cmd_ready;
   addr_t      eai_icb_cmd_addr;
   logic       eai_icb_cmd_read;
   xlen_t      eai_icb_cmd_wdata;
   logic [1:0] eai_icb_cmd_size;
   logic       eai_icb_rsp_valid;
   logic       eai_icb_rsp_ready;
   xlen_t      eai_icb_rsp_rdata;
   logic       eai_icb_rsp_err;

   int    mismatch_cnt = 0;
   int    other_cnt = 0;
   bit    stall_en = 1'b0;
   addr_t addr_log[$];
   addr_t cur_base;
   xlen_t cur_len;
   xlen_t exp_col [`EAI_MATRIX_DIM] = '{default: '0};

   eai_matrix_core dut (.*);

   initial
   begin
      eai_clk = 1'b0;
      forever #(CLK_PERIOD / 2) eai_clk = ~eai_clk;
   end

   // every address bit reaches the word
   function automatic xlen_t mem_word(input addr_t a);
      return (a * 32'h0001_0003) ^ 32'h00a5_5a00;
   endfunction

   function automatic xlen_t make_inst(input logic [6:0] f7, input logic [2:0] f3);
      return {f7, 5'd2, 5'd1, f3, 5'd3, `EAI_OPC_CUSTOM0};
   endfunction

   // =========================================================================
   // icb memory model, one read outstanding
   // =========================================================================
   initial
   begin
      addr_t pend_addr;
      int    rsp_cnt;
      int    cmd_age;
      pend_addr = '0;
      rsp_cnt = 0;
      cmd_age = 0;
      eai_icb_cmd_ready = 1'b1;
      eai_icb_rsp_valid = 1'b0;
      eai_icb_rsp_rdata = '0;
      eai_icb_rsp_err = 1'b0;
      forever
      begin
         @(negedge eai_clk);
         eai_icb_rsp_valid = 1'b0;
         if (rsp_cnt > 0)
         begin
            rsp_cnt--;
            if (rsp_cnt == 0)
            begin
               eai_icb_rsp_valid = 1'b1;
               eai_icb_rsp_rdata = mem_word(pend_addr);
            end
         end
         // when stalling, each new command is refused at least once
         if (stall_en)
            eai_icb_cmd_ready = (cmd_age > 0) && (($urandom % 4) != 0);
         else
            eai_icb_cmd_ready = 1'b1;
         if (eai_icb_cmd_valid && eai_icb_cmd_ready)
         begin
            check_bit("icb_cmd_read", eai_icb_cmd_read, 1'b1);
            check_word("icb_cmd_wdata", eai_icb_cmd_wdata, '0);
            check_word("icb_cmd_size", xlen_t'(eai_icb_cmd_size), 32'd2);
            pend_addr = eai_icb_cmd_addr;
            addr_log.push_back(eai_icb_cmd_addr);
            rsp_cnt = 1 + ($urandom % 3);
            cmd_age = 0;
         end
         else if (eai_icb_cmd_valid)
            cmd_age++;
      end
   end

   task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
      if (got !== exp)
      begin
         $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
         mismatch_cnt++;
      end
   endtask

   task automatic check_addr(input string name, input addr_t got, input addr_t exp);
      if (got !== exp)
      begin
         $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
         mismatch_cnt++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
         mismatch_cnt++;
      end
   endtask

   task automatic report_fail(input string msg);
      $display("Error: %s", msg);
      other_cnt++;
   endtask

   task automatic send_req(input xlen_t inst, input xlen_t rs1, input xlen_t rs2);
      eai_req_valid = 1'b1;
      eai_req_inst  = inst;
      eai_req_rs1   = rs1;
      eai_req_rs2   = rs2;
      while (!eai_req_ready)
         @(negedge eai_clk);
      @(negedge eai_clk);
      eai_req_valid = 1'b0;
   endtask

   // hold keeps rsp_ready low for that many cycles once rsp_valid is up
   task automatic wait_rsp(input int hold, input logic holdup, output xlen_t data);
      int    n;
      xlen_t held;
      n = 0;
      data = '0;
      while (!eai_rsp_valid && n < RSP_LIMIT)
      begin
         if (holdup)
            check_bit("mem_holdup", eai_mem_holdup, 1'b1);
         check_bit("req_ready", eai_req_ready, 1'b0);
         @(negedge eai_clk);
         n++;
      end
      if (!eai_rsp_valid)
      begin
         report_fail("no response from the DUT within the wait limit");
         return;
      end
      held = eai_rsp_rdat;
      repeat (hold)
      begin
         @(negedge eai_clk);
         check_bit("rsp_valid", eai_rsp_valid, 1'b1);
         check_word("rsp_rdat", eai_rsp_rdat, held);
         check_bit("req_ready", eai_req_ready, 1'b0);
         if (holdup)
            check_bit("mem_holdup", eai_mem_holdup, 1'b1);
      end
      check_bit("rsp_err", eai_rsp_err, 1'b0);
      data = eai_rsp_rdat;
      eai_rsp_ready = 1'b1;
      @(negedge eai_clk);
      eai_rsp_ready = 1'b0;
   endtask

   task automatic do_setup(input addr_t base, input xlen_t len);
      xlen_t got;
      cur_base = base;
      cur_len  = len;
      send_req(make_inst(`EAI_F7_SETUP, `EAI_F3_SETUP), base, len);
      wait_rsp(0, 1'b0, got);
      check_word("rsp_rdat", got, '0);
   endtask

   task automatic run_row(input xlen_t row, input int hold, output xlen_t got);
      addr_t exp_addr;
      xlen_t exp_sum;
      addr_log.delete();
      exp_sum = '0;
      send_req(make_inst(`EAI_F7_ROWSUM, `EAI_F3_SUM), row, '0);
      wait_rsp(hold, 1'b1, got);
      if (addr_log.size() != `EAI_MATRIX_DIM)
         report_fail("wrong number of memory reads in a row sum");
      for (int k = 0; k < `EAI_MATRIX_DIM; k++)
      begin
         exp_addr = cur_base + addr_t'(row * cur_len * 4) + addr_t'(k * 4);
         if (k < addr_log.size())
            check_addr("icb_cmd_addr", addr_log[k], exp_addr);
         exp_sum += mem_word(exp_addr);
         // row 0 restarts the column totals
         exp_col[k] = (row == '0) ? mem_word(exp_addr) : exp_col[k] + mem_word(exp_addr);
      end
      check_word("rsp_rdat", got, exp_sum);
      check_bit("mem_holdup", eai_mem_holdup, 1'b0);
   endtask

   task automatic col_sum(input int col);
      xlen_t got;
      send_req(make_inst(`EAI_F7_COLSUM, `EAI_F3_SUM), xlen_t'(col), '0);
      wait_rsp(0, 1'b0, got);
      check_word("rsp_rdat", got, (col < `EAI_MATRIX_DIM) ? exp_col[col] : '0);
   endtask

   task automatic test_reset();
      check_bit("rsp_valid", eai_rsp_valid, 1'b0);
      check_bit("icb_cmd_valid", eai_icb_cmd_valid, 1'b0);
      check_bit("mem_holdup", eai_mem_holdup, 1'b0);
      check_bit("req_ready", eai_req_ready, 1'b1);
      check_bit("active", eai_active, 1'b1);
      check_bit("icb_rsp_ready", eai_icb_rsp_ready, 1'b1);
   endtask

   task automatic test_row_sum();
      xlen_t got;
      do_setup(32'h0000_1000, 32'd5);
      run_row(32'd2, 0, got);
   endtask

   task automatic test_col_sums();
      xlen_t got;
      do_setup(32'h0000_4000, 32'd3);
      for (int r = 0; r < 3; r++)
         run_row(xlen_t'(r), 0, got);
      for (int c = 0; c < 4; c++)
         col_sum(c);
      run_row(32'd0, 0, got);
      for (int c = 0; c < 3; c++)
         col_sum(c);
   endtask

   task automatic test_backpressure();
      xlen_t got;
      stall_en = 1'b1;
      do_setup(32'h0000_1000, 32'd5);
      run_row(32'd2, 4, got);
      stall_en = 1'b0;
   endtask

   task automatic test_undecoded();
      send_req(32'h0000_0033, 32'd1, 32'd2);
      repeat (10)
      begin
         check_bit("rsp_valid", eai_rsp_valid, 1'b0);
         check_bit("icb_cmd_valid", eai_icb_cmd_valid, 1'b0);
         @(negedge eai_clk);
      end
      check_bit("req_ready", eai_req_ready, 1'b1);
      do_setup(32'h0000_8000, 32'd4);
   endtask

   initial
   begin
      void'($urandom(84172));
      eai_rst_n     = 1'b0;
      eai_req_valid = 1'b0;
      eai_req_inst  = '0;
      eai_req_rs1   = '0;
      eai_req_rs2   = '0;
      eai_rsp_ready = 1'b0;
      repeat (4) @(negedge eai_clk);
      eai_rst_n = 1'b1;
      test_reset();
      test_row_sum();
      test_col_sums();
      test_backpressure();
      test_undecoded();
      $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
      if (mismatch_cnt + other_cnt == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

   // watchdog sized from the test count
   initial
   begin
      #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
      $display("Error: watchdog timeout, the tests did not finish");
      $display(">>> FAIL");
      $finish;
   end

endmodule
